/* logic/isa_pkg.sv */
package isa_pkg;

   typedef logic [15:0] word_t;    // data and instruction word
   typedef logic [2:0]  reg_idx_t;

   localparam int num_regs = 8;
   localparam reg_idx_t reg_pc   = 3'd6;
   localparam reg_idx_t reg_flag = 3'd7;
   localparam int flag_zero = 0;    // bit of reg_flag

   localparam word_t reg_reset_value = 16'hffff;  // r0..r5 after reset
   localparam word_t pc_step = 16'd2;              // byte addresses, one word per step

   // major opcode in bits 15:12
   typedef enum logic [3:0] {
      op_nop   = 4'h0,
      op_ldi   = 4'h1,   // bit 11 high half, 10:8 dest, 7:0 imm
      op_arith = 4'h2,   // 11:9 func, 8:6 dest, 5:3 a, 2:0 b
      op_xfer  = 4'h3,   // 5:3 data/dest, 2:0 addr/source
      op_halt  = 4'hf    // low 12 bits zero
   } opcode_t;

   // arith function, bits 11:9
   localparam logic [2:0] fn_add = 3'd0;
   localparam logic [2:0] fn_sub = 3'd1;

   // xfer bus accesses: bits 11:9, bit 8 selects i/o space
   localparam logic [2:0] xfer_bus = 3'b000;

   // access kind in bits 7:6
   localparam logic [1:0] xfer_st_w = 2'b00;
   localparam logic [1:0] xfer_ld_w = 2'b01;
   localparam logic [1:0] xfer_st_b = 2'b10;
   localparam logic [1:0] xfer_ld_b = 2'b11;

   // plain move, whole of bits 11:6
   localparam logic [5:0] xfer_move = 6'b0010_00;

   // conditional moves in bits 11:10, flag number in 9:6
   localparam logic [1:0] xfer_mv_nf = 2'b01;  // move if flag clear
   localparam logic [1:0] xfer_mv_f  = 2'b10;  // move if flag set

endpackage

/* logic/bus_pkg.sv */
package bus_pkg;

   // kind of transfer on the shared bus
   typedef enum logic [1:0] {
      cmd_read    = 2'b00,
      cmd_write   = 2'b01,
      cmd_read_b  = 2'b10,
      cmd_write_b = 2'b11
   } bus_cmd_t;

   // which target a request goes to
   typedef logic bus_sel_t;
   localparam bus_sel_t sel_mem = 1'b0;
   localparam bus_sel_t sel_io  = 1'b1;

   localparam int mem_addr_bits = 15;                  // word address width
   localparam int mem_words     = 1 << mem_addr_bits;  // 32K words

   // i/o map
   localparam logic [15:0] io_uart_addr = 16'h0000;    // uart tx, byte writes only

endpackage

/* logic/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
   parameter int clks_per_bit = 234
) (
   input  logic       sysclk,
   input  logic       reset,
   input  logic [7:0] data,
   input  logic       start,
   output logic       busy,
   output logic       txd
);

   localparam int cnt_bits = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
   localparam logic [cnt_bits-1:0] last_tick = cnt_bits'(clks_per_bit - 1);

   logic [cnt_bits-1:0] tick_cnt;   // clocks within the current bit
   logic [3:0]          bit_idx;    // 0 start, 1..8 data, 9 stop
   logic [8:0]          shifter;    // data bits then stop bit
   logic                load;
   logic                bit_end;

   assign load    = start && !busy;
   assign bit_end = busy && (tick_cnt == last_tick);

   always_ff @(posedge sysclk) begin
      if (reset) begin
         busy     <= 1'b0;
         txd      <= 1'b1;   // line idles high
         tick_cnt <= '0;
         bit_idx  <= '0;
      end else if (load) begin
         busy     <= 1'b1;
         txd      <= 1'b0;   // start bit
         tick_cnt <= '0;
         bit_idx  <= '0;
      end else if (bit_end) begin
         tick_cnt <= '0;
         if (bit_idx == 4'd9) begin
            busy <= 1'b0;
            txd  <= 1'b1;
         end else begin
            bit_idx <= bit_idx + 4'd1;
            txd     <= shifter[0];
         end
      end else if (busy) begin
         tick_cnt <= tick_cnt + 1'b1;
      end
   end

   // lsb first, stop bit shifted in behind the data
   always_ff @(posedge sysclk) begin
      if (load)
         shifter <= {1'b1, data};
      else if (bit_end)
         shifter <= {1'b1, shifter[8:1]};
   end

endmodule

/* logic/io_port.sv */
`timescale 1ns/1ps

module io_port #(
   parameter int clks_per_bit = 234
) (
   input  logic              sysclk,
   input  logic              reset,
   input  isa_pkg::word_t    addr,
   input  bus_pkg::bus_cmd_t cmd,
   input  logic              run,
   input  isa_pkg::word_t    wr_data,
   output isa_pkg::word_t    rd_data,
   output logic              done,
   output logic              uart_txp
);

   typedef enum logic {st_idle, st_wait_uart} state_t;

   state_t     state;
   logic       req;
   logic       is_uart_wr;
   logic       uart_free;
   logic       launch;
   logic       uart_start;
   logic       uart_busy;
   logic [7:0] uart_data;

   assign req        = (run != done);
   assign is_uart_wr = (addr == bus_pkg::io_uart_addr) && (cmd == bus_pkg::cmd_write_b);
   assign uart_free  = !uart_busy && !uart_start;  // busy rises one edge after start
   assign launch     = uart_free &&
                       ((state == st_idle && req && is_uart_wr) || state == st_wait_uart);

   assign rd_data = '0;  // nothing readable yet

   always_ff @(posedge sysclk) begin
      if (reset) begin
         state      <= st_idle;
         done       <= 1'b0;
         uart_start <= 1'b0;
      end else begin
         uart_start <= launch;
         case (state)
            st_idle: begin
               if (req) begin
                  if (!is_uart_wr)
                     done <= ~done;  // unmapped, finish right away
                  else if (launch)
                     done <= ~done;
                  else
                     state <= st_wait_uart;
               end
            end
            st_wait_uart: begin
               if (launch) begin
                  done  <= ~done;
                  state <= st_idle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge sysclk) begin
      if (launch)
         uart_data <= wr_data[7:0];
   end

   uart_tx #(.clks_per_bit(clks_per_bit)) tx (
      .sysclk (sysclk),
      .reset  (reset),
      .data   (uart_data),
      .start  (uart_start),
      .busy   (uart_busy),
      .txd    (uart_txp)
   );

   a_no_overrun: assert property (@(posedge sysclk) disable iff (reset)
      uart_start |-> !uart_busy)
      else $error("uart start while busy");

endmodule

/* logic/word_memory.sv */
`timescale 1ns/1ps

module word_memory (
   input  logic              sysclk,
   input  logic              reset,
   input  isa_pkg::word_t    addr,
   input  bus_pkg::bus_cmd_t cmd,
   input  logic              run,
   input  isa_pkg::word_t    wr_data,
   output isa_pkg::word_t    rd_data,
   output logic              done
);

   isa_pkg::word_t words [bus_pkg::mem_words];  // loaded from outside

   logic [bus_pkg::mem_addr_bits-1:0] waddr;
   logic access;

   assign waddr  = addr[bus_pkg::mem_addr_bits:1];
   assign access = (run != done) && !reset;

   always_ff @(posedge sysclk) begin
      if (access) begin
         case (cmd)
            bus_pkg::cmd_read:  rd_data <= words[waddr];
            bus_pkg::cmd_write: words[waddr] <= wr_data;
            bus_pkg::cmd_read_b: begin
               if (addr[0])
                  rd_data <= {8'h00, words[waddr][15:8]};
               else
                  rd_data <= {8'h00, words[waddr][7:0]};
            end
            bus_pkg::cmd_write_b: begin
               if (addr[0])
                  words[waddr][15:8] <= wr_data[7:0];  // odd byte, upper lane
               else
                  words[waddr][7:0] <= wr_data[7:0];
            end
         endcase
      end
   end

   // answers every request on the next edge
   always_ff @(posedge sysclk) begin
      if (reset)
         done <= 1'b0;
      else if (access)
         done <= ~done;
   end

   a_one_cycle: assert property (@(posedge sysclk) disable iff (reset)
      (run != done) |=> (run == done))
      else $error("memory request left open longer than one cycle");

endmodule

/* logic/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
   input  logic              sysclk,
   input  logic              reset,
   output isa_pkg::word_t    bus_addr,
   output bus_pkg::bus_cmd_t bus_cmd,
   output isa_pkg::word_t    bus_wr_data,
   output logic              mem_run,
   output logic              io_run,
   input  isa_pkg::word_t    mem_rd_data,
   input  isa_pkg::word_t    io_rd_data,
   input  logic              mem_done,
   input  logic              io_done,
   output logic              halted,
   output isa_pkg::word_t    r0
);

   typedef enum logic {st_exec, st_complete} state_t;

   isa_pkg::word_t    regs [isa_pkg::num_regs];
   state_t            state;
   isa_pkg::reg_idx_t ld_reg;    // destination of a pending load
   bus_pkg::bus_sel_t acc_sel;   // target of the pending access

   logic              busy;
   isa_pkg::word_t    ins;
   isa_pkg::opcode_t  opcode;
   isa_pkg::word_t    a_val, b_val, d_val;
   isa_pkg::word_t    alu_val, pc_inc, pc_next;
   logic              flag_hit;

   // decoded execute step
   logic              rf_we;
   isa_pkg::reg_idx_t rf_idx;
   isa_pkg::word_t    rf_val;
   logic              zf_we;
   logic              do_halt;
   logic              req_go;
   bus_pkg::bus_sel_t req_sel;
   bus_pkg::bus_cmd_t req_cmd;

   // access completion
   logic              is_load;
   isa_pkg::word_t    rd_sel_data, ld_val, fetch_addr;

   assign busy = (mem_run != mem_done) || (io_run != io_done);

   assign ins    = mem_rd_data;  // fetched word stays on the memory read port
   assign opcode = isa_pkg::opcode_t'(ins[15:12]);
   assign a_val  = regs[ins[5:3]];
   assign b_val  = regs[ins[2:0]];
   assign d_val  = regs[ins[10:8]];
   assign pc_inc = regs[isa_pkg::reg_pc] + isa_pkg::pc_step;
   assign flag_hit = regs[isa_pkg::reg_flag][ins[9:6]];

   always_comb begin
      rf_we   = 1'b0;
      rf_idx  = ins[10:8];
      rf_val  = d_val;
      alu_val = a_val + b_val;
      zf_we   = 1'b0;
      do_halt = 1'b0;
      req_go  = 1'b0;
      req_sel = bus_pkg::sel_mem;
      req_cmd = bus_pkg::cmd_read;
      case (opcode)
         isa_pkg::op_nop: ;
         isa_pkg::op_ldi: begin
            rf_we = 1'b1;
            if (ins[11])
               rf_val = {ins[7:0], d_val[7:0]};
            else
               rf_val = {d_val[15:8], ins[7:0]};
         end
         isa_pkg::op_arith: begin
            case (ins[11:9])
               isa_pkg::fn_add: begin
                  alu_val = a_val + b_val;
                  rf_we   = 1'b1;
                  zf_we   = 1'b1;
               end
               isa_pkg::fn_sub: begin
                  alu_val = a_val - b_val;
                  rf_we   = 1'b1;
                  zf_we   = 1'b1;
               end
               default: ;  // unknown function, no effect
            endcase
            rf_idx = ins[8:6];
            rf_val = alu_val;
         end
         isa_pkg::op_xfer: begin
            rf_idx = ins[5:3];
            rf_val = b_val;
            if (ins[11:9] == isa_pkg::xfer_bus) begin
               req_go  = 1'b1;
               req_sel = ins[8];
               case (ins[7:6])
                  isa_pkg::xfer_st_w: req_cmd = bus_pkg::cmd_write;
                  isa_pkg::xfer_ld_w: req_cmd = bus_pkg::cmd_read;
                  isa_pkg::xfer_st_b: req_cmd = bus_pkg::cmd_write_b;
                  isa_pkg::xfer_ld_b: req_cmd = bus_pkg::cmd_read_b;
               endcase
            end else if (ins[11:6] == isa_pkg::xfer_move) begin
               rf_we = 1'b1;
            end else if (ins[11:10] == isa_pkg::xfer_mv_nf) begin
               rf_we = !flag_hit;
            end else if (ins[11:10] == isa_pkg::xfer_mv_f) begin
               rf_we = flag_hit;
            end
         end
         isa_pkg::op_halt: do_halt = (ins[11:0] == 12'h000);
         default: ;
      endcase
   end

   // a write to the pc redirects the next fetch
   assign pc_next = (rf_we && rf_idx == isa_pkg::reg_pc) ? rf_val : pc_inc;

   assign is_load     = (bus_cmd == bus_pkg::cmd_read) || (bus_cmd == bus_pkg::cmd_read_b);
   assign rd_sel_data = (acc_sel == bus_pkg::sel_io) ? io_rd_data : mem_rd_data;
   assign ld_val      = (bus_cmd == bus_pkg::cmd_read_b) ?
                        {regs[ld_reg][15:8], rd_sel_data[7:0]} : rd_sel_data;
   assign fetch_addr  = (is_load && ld_reg == isa_pkg::reg_pc) ?
                        ld_val : regs[isa_pkg::reg_pc];

   always_ff @(posedge sysclk) begin
      if (reset) begin
         for (int i = 0; i < isa_pkg::num_regs; i++) begin
            regs[i] <= isa_pkg::reg_reset_value;
         end
         regs[isa_pkg::reg_pc]   <= '0;
         regs[isa_pkg::reg_flag] <= '0;
         state       <= st_exec;
         halted      <= 1'b0;
         bus_addr    <= '0;          // first fetch from 0
         bus_cmd     <= bus_pkg::cmd_read;
         bus_wr_data <= '0;
         mem_run     <= 1'b1;        // memory done resets low
         io_run      <= 1'b0;
         acc_sel     <= bus_pkg::sel_mem;
         ld_reg      <= '0;
      end else if (!halted && !busy) begin
         case (state)
            st_exec: begin
               if (rf_we)
                  regs[rf_idx] <= rf_val;
               if (zf_we)
                  regs[isa_pkg::reg_flag][isa_pkg::flag_zero] <= (alu_val == '0);
               regs[isa_pkg::reg_pc] <= pc_next;
               if (do_halt) begin
                  halted <= 1'b1;
               end else if (req_go) begin
                  bus_addr    <= b_val;
                  bus_cmd     <= req_cmd;
                  bus_wr_data <= a_val;
                  acc_sel     <= req_sel;
                  ld_reg      <= ins[5:3];
                  if (req_sel == bus_pkg::sel_io)
                     io_run <= ~io_run;
                  else
                     mem_run <= ~mem_run;
                  state <= st_complete;
               end else begin
                  bus_addr <= pc_next;    // next fetch
                  bus_cmd  <= bus_pkg::cmd_read;
                  mem_run  <= ~mem_run;
               end
            end
            st_complete: begin
               if (is_load)
                  regs[ld_reg] <= ld_val;
               bus_addr <= fetch_addr;
               bus_cmd  <= bus_pkg::cmd_read;
               mem_run  <= ~mem_run;
               state    <= st_exec;
            end
         endcase
      end
   end

   assign r0 = regs[0];

   // requester holds the shared bus until the target answers
   a_bus_stable: assert property (@(posedge sysclk)
      (!$past(reset) && $past(busy)) |->
         ($stable(bus_addr) && $stable(bus_cmd) && $stable(bus_wr_data)))
      else $error("bus signals changed during an outstanding request");

   a_halt_sticky: assert property (@(posedge sysclk) $fell(halted) |-> $past(reset))
      else $error("halted fell without reset");

endmodule

/* logic/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
   parameter int clks_per_bit = 234
) (
   input  logic           sysclk,
   input  logic           reset,
   output logic           uart_txp,
   output logic           halted,
   output isa_pkg::word_t r0      // debug view of register 0
);

   isa_pkg::word_t    bus_addr;
   bus_pkg::bus_cmd_t bus_cmd;
   isa_pkg::word_t    bus_wr_data;
   logic              mem_run, mem_done;
   logic              io_run, io_done;
   isa_pkg::word_t    mem_rd_data, io_rd_data;

   cpu_core core (
      .sysclk      (sysclk),
      .reset       (reset),
      .bus_addr    (bus_addr),
      .bus_cmd     (bus_cmd),
      .bus_wr_data (bus_wr_data),
      .mem_run     (mem_run),
      .io_run      (io_run),
      .mem_rd_data (mem_rd_data),
      .io_rd_data  (io_rd_data),
      .mem_done    (mem_done),
      .io_done     (io_done),
      .halted      (halted),
      .r0          (r0)
   );

   word_memory mem (
      .sysclk  (sysclk),
      .reset   (reset),
      .addr    (bus_addr),
      .cmd     (bus_cmd),
      .run     (mem_run),
      .wr_data (bus_wr_data),
      .rd_data (mem_rd_data),
      .done    (mem_done)
   );

   io_port #(.clks_per_bit(clks_per_bit)) io (
      .sysclk   (sysclk),
      .reset    (reset),
      .addr     (bus_addr),
      .cmd      (bus_cmd),
      .run      (io_run),
      .wr_data  (bus_wr_data),
      .rd_data  (io_rd_data),
      .done     (io_done),
      .uart_txp (uart_txp)
   );

endmodule

/* tb/tb_programs.svh */
// one row per behavior under test
// columns: name, program words from word 0, data words from word 0x1010,
// expected uart bytes and their count, expected r0 at halt, spin program first

localparam int n_rows    = 6;
localparam int prog_len  = 24;
localparam int data_len  = 8;
localparam int max_bytes = 12;
localparam int data_word = 'h1010;   // byte address 0x2020

string row_name [n_rows] = '{
   "immediate halves", "countdown loop", "word and byte memory",
   "text output", "back-to-back output", "reset mid-run"
};

// unused slots hold halt so a stray fetch stops the core
logic [15:0] prog_tab [n_rows][prog_len] = '{
   // ldi hi r0,0xbe then ldi lo r0,0xef
   '{16'h18be, 16'h10ef, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000,
     16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000,
     16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000},
   // r0 counts 4 down to 0, r2 marker from '0' sent each pass, loop at 0x12
   '{16'h1004, 16'h1800, 16'h1101, 16'h1900, 16'h1230, 16'h1300, 16'h1b00, 16'h1412,
     16'h1c00, 16'h3193, 16'h2091, 16'h2201, 16'h3434, 16'hf000, 16'hf000, 16'hf000,
     16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000},
   // store 0xa1b2 at 0x2020, byte 0xc3 to 0x2021, reload word and odd byte, add
   '{16'h1120, 16'h1920, 16'h10b2, 16'h18a1, 16'h3001, 16'h12c3, 16'h1321, 16'h1b20,
     16'h3093, 16'h3061, 16'h1d00, 16'h30eb, 16'h2025, 16'hf000, 16'hf000, 16'hf000,
     16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000},
   // walk bytes from 0x2020 until a zero byte, loop at 0x18, exit at 0x24
   '{16'h1000, 16'h1800, 16'h1120, 16'h1920, 16'h1201, 16'h1a00, 16'h1300, 16'h1b00,
     16'h1418, 16'h1c00, 16'h1524, 16'h1d00, 16'h30c1, 16'h2003, 16'h3835, 16'h3183,
     16'h204a, 16'h3234, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000},
   // six byte outputs in a row
   '{16'h1300, 16'h1b00, 16'h1055, 16'h11a3, 16'h120f, 16'h14f0, 16'h1581, 16'h3183,
     16'h318b, 16'h3193, 16'h31a3, 16'h31ab, 16'h3183, 16'hf000, 16'hf000, 16'hf000,
     16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000},
   // skips the add if a stale zero flag survived, else r0 = r1 + r2 and send it
   '{16'h1410, 16'h1c00, 16'h3834, 16'h200a, 16'h1300, 16'h1b00, 16'h3183, 16'hf000,
     16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000,
     16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000}
};

// r0 = 0 with zero flag set, then jumps to itself forever
logic [15:0] spin_prog [prog_len] = '{
   16'h2200, 16'h1406, 16'h1c00, 16'h3234, 16'hf000, 16'hf000, 16'hf000, 16'hf000,
   16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000,
   16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000, 16'hf000
};

logic [15:0] data_tab [n_rows][data_len] = '{
   '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
   '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
   '{16'h5a5a, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
   '{16'h6548, 16'h6c6c, 16'h206f, 16'h5043, 16'h2155, 16'h0000, 16'h0000, 16'h0000},
   '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
   '{16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
};

logic [7:0] exp_bytes [n_rows][max_bytes] = '{
   '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
   '{8'h30, 8'h31, 8'h32, 8'h33, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
   '{8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
   '{8'h48, 8'h65, 8'h6c, 8'h6c, 8'h6f, 8'h20, 8'h43, 8'h50, 8'h55, 8'h21, 8'h00, 8'h00},
   '{8'h55, 8'ha3, 8'h0f, 8'hf0, 8'h81, 8'h55, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00},
   '{8'hfe, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00}
};

int          exp_count  [n_rows] = '{0, 4, 0, 10, 6, 1};
logic [15:0] exp_r0     [n_rows] = '{16'hbeef, 16'h0000, 16'hc475, 16'h0000, 16'hff55, 16'hfffe};
bit          spin_first [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

/* tb/cpu_top_tb.sv */
`timescale 1ns/1ps

module cpu_top_tb;

   localparam int clks_per_bit = 8;
   localparam int clk_period   = 20;                 // ns
   localparam int bit_ns       = clks_per_bit * clk_period;
   localparam int reset_cycles = 4;
   localparam int row_budget   = 20000;              // cycles per table row
   localparam int halt_budget  = row_budget / 2;
   localparam int spin_cycles  = 300;
   localparam int drain_cycles = 20 * clks_per_bit;  // last frame still on the line

   `include "tb_programs.svh"

   localparam longint watchdog_ns = longint'(n_rows) * row_budget * clk_period;

   logic           sysclk = 1'b0;
   logic           reset  = 1'b1;
   logic           uart_txp;
   logic           halted;
   isa_pkg::word_t r0;

   logic [7:0] rx_q [$];   // bytes seen on the uart line

   cpu_top #(.clks_per_bit(clks_per_bit)) uut (
      .sysclk   (sysclk),
      .reset    (reset),
      .uart_txp (uart_txp),
      .halted   (halted),
      .r0       (r0)
   );

   always #(clk_period / 2) sysclk = ~sysclk;

   task automatic check_value(input logic [15:0] actual, input logic [15:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         $display("Checks failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // program goes in while reset holds the bus idle
   task automatic load_and_restart(input int row, input bit spin);
      @(posedge sysclk);
      #2;
      reset = 1'b1;
      for (int i = 0; i < prog_len; i++) begin
         uut.mem.words[i] = spin ? spin_prog[i] : prog_tab[row][i];
      end
      for (int i = 0; i < data_len; i++) begin
         uut.mem.words[data_word + i] = data_tab[row][i];
      end
      rx_q.delete();
      repeat (reset_cycles) @(posedge sysclk);
      #2;
      reset = 1'b0;
   endtask

   // 8n1 receiver, samples mid-bit
   initial begin : uart_receiver
      logic [7:0] rx;
      forever begin
         @(negedge uart_txp);
         #(bit_ns / 2);
         if (uart_txp == 1'b0) begin
            for (int i = 0; i < 8; i++) begin
               #(bit_ns);
               rx[i] = uart_txp;   // lsb first
            end
            #(bit_ns);
            check_value(16'(uart_txp), 16'h0001, "uart stop bit");
            rx_q.push_back(rx);
         end
      end
   end

   initial begin : watchdog
      #(watchdog_ns);
      $display("timeout: the run did not finish within %0d cycles", n_rows * row_budget);
      $display("Checks failed");
      $fatal(1, "watchdog expired");
   end

   initial begin : test_sequence
      int waited;
      for (int row = 0; row < n_rows; row++) begin
         if (spin_first[row]) begin
            load_and_restart(row, 1'b1);
            repeat (spin_cycles) @(posedge sysclk);
            #2;
            check_value(16'(halted), 16'h0000, "spin program halted");
            check_value(r0, 16'h0000, "spin program r0");
         end
         load_and_restart(row, 1'b0);   // interrupts the spin loop where there is one
         check_value(16'(halted), 16'h0000, $sformatf("%s: halted after reset", row_name[row]));

         waited = 0;
         while (!halted && waited < halt_budget) begin
            @(posedge sysclk);
            #2;
            waited++;
         end
         if (!halted) begin
            $display("%s: the program did not halt within %0d cycles",
                     row_name[row], halt_budget);
            $display("Checks failed");
            $fatal(1, "no halt");
         end

         repeat (drain_cycles) @(posedge sysclk);
         #2;
         check_value(r0, exp_r0[row], $sformatf("%s: r0 at halt", row_name[row]));
         check_value(16'(rx_q.size()), 16'(exp_count[row]),
                     $sformatf("%s: uart byte count", row_name[row]));
         for (int i = 0; i < rx_q.size(); i++) begin
            check_value(16'(rx_q[i]), 16'(exp_bytes[row][i]),
                        $sformatf("%s: uart byte %0d", row_name[row], i));
         end
      end
      $display("All checks passed");
      $finish;
   end

endmodule

/* build.f */
+incdir+tb
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/uart_tx.sv
logic/io_port.sv
logic/word_memory.sv
logic/cpu_core.sv
logic/cpu_top.sv
tb/cpu_top_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert --top-module cpu_top_tb -f build.f -o cpu_top_sim; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/cpu_top_sim > "$log" 2>&1; then
   cat "$log"
   echo "simulation returned an error status"
   exit 1
fi

cat "$log"

if grep -qx "All checks passed" "$log"; then
   exit 0
else
   echo "pass message not found in $log"
   exit 1
fi
